// File: logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int xlen  = 32;
    localparam int tag_w = 8;

    localparam logic [2:0] f3_b  = 3'b000;
    localparam logic [2:0] f3_h  = 3'b001;
    localparam logic [2:0] f3_w  = 3'b010;
    localparam logic [2:0] f3_bu = 3'b100;
    localparam logic [2:0] f3_hu = 3'b101;

    localparam logic [1:0] cov_none = 2'b00;
    localparam logic [1:0] cov_part = 2'b01; // Some needed bytes forwarded
    localparam logic [1:0] cov_full = 2'b11;

    // SB and SH land in the low byte or halfword of the word
    function automatic logic [3:0] store_mask(input logic [2:0] f3);
        case (f3)
            f3_b:    return 4'b0001;
            f3_h:    return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [3:0] load_mask(input logic [2:0] f3);
        case (f3)
            f3_b, f3_bu: return 4'b0001;
            f3_h, f3_hu: return 4'b0011;
            default:     return 4'b1111;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: logic/store_buffer.sv
`default_nettype none

module store_buffer
    import lsu_pkg::*;
#(
    parameter int depth = 8
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            exception,
    input  logic            memwrite,
    input  logic            memread,
    input  logic [2:0]      funct3,
    input  logic [xlen-1:0] mem_addr,
    input  logic [xlen-1:0] mem_data,
    input  logic [xlen-1:0] inst_num,
    input  logic            memwrite_rob,
    input  logic [xlen-1:0] mem_addr_rob,
    input  logic [xlen-1:0] inst_num_rob,
    output logic            full,
    output logic [xlen-1:0] fwd_data,
    output logic [3:0]      fwd_mask,
    output logic            ram_we,
    output logic [xlen-1:0] ram_addr,
    output logic [xlen-1:0] ram_wdata,
    output logic [3:0]      ram_be
);

    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;

    logic [xlen-1:0]  ent_addr [depth];
    logic [xlen-1:0]  ent_data [depth];
    logic [3:0]       ent_mask [depth];
    logic [xlen-1:0]  ent_inum [depth];
    logic [depth-1:0] ent_valid;

    logic [depth-1:0] addr_hit; // Live entry for mem_addr
    logic [depth-1:0] rob_hit;  // Entry named by the commit
    logic [idx_w-1:0] hit_idx;
    logic [idx_w-1:0] rob_idx;
    logic [idx_w-1:0] free_idx;
    logic             any_hit;
    logic             any_rob;
    logic [3:0]       st_mask;
    logic             do_commit;
    logic             do_merge;
    logic             do_alloc;

    always_comb begin
        for (int i = 0; i < depth; i++) begin
            addr_hit[i] = ent_valid[i] && (ent_addr[i] == mem_addr);
            rob_hit[i]  = ent_valid[i] && (ent_addr[i] == mem_addr_rob)
                          && (ent_inum[i] == inst_num_rob);
        end
    end

    // Lowest index wins in each encoder
    always_comb begin
        hit_idx  = '0;
        rob_idx  = '0;
        free_idx = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (addr_hit[i]) begin
                hit_idx = idx_w'(i);
            end
            if (rob_hit[i]) begin
                rob_idx = idx_w'(i);
            end
            if (!ent_valid[i]) begin
                free_idx = idx_w'(i);
            end
        end
    end

    assign any_hit = |addr_hit;
    assign any_rob = |rob_hit;
    assign full    = &ent_valid;
    assign st_mask = store_mask(funct3);

    assign do_commit = memwrite_rob && any_rob && !exception;
    assign do_merge  = memwrite && any_hit && !exception;
    assign do_alloc  = memwrite && !any_hit && !full && !exception; // Dropped when full

    // Committed entry goes straight to the RAM port
    assign ram_we    = do_commit;
    assign ram_addr  = mem_addr_rob;
    assign ram_wdata = ent_data[rob_idx];
    assign ram_be    = ent_mask[rob_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ent_valid <= '0;
        end else if (exception) begin
            ent_valid <= '0;
        end else begin
            if (do_commit) begin
                ent_valid[rob_idx] <= 1'b0;
            end
            // A merge keeps the entry alive even if its older store commits now
            if (do_merge) begin
                ent_valid[hit_idx] <= 1'b1;
            end else if (do_alloc) begin
                ent_valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_merge) begin
            for (int b = 0; b < 4; b++) begin
                if (st_mask[b]) begin
                    ent_data[hit_idx][8*b +: 8] <= mem_data[8*b +: 8];
                end
            end
            ent_mask[hit_idx] <= ent_mask[hit_idx] | st_mask;
            ent_inum[hit_idx] <= inst_num; // Younger store now owns the entry
        end else if (do_alloc) begin
            ent_addr[free_idx] <= mem_addr;
            ent_data[free_idx] <= mem_data;
            ent_mask[free_idx] <= st_mask;
            ent_inum[free_idx] <= inst_num;
        end
    end

    // Load lookup, lined up with the RAM read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fwd_mask <= '0;
        end else if (memread) begin
            fwd_mask <= any_hit ? ent_mask[hit_idx] : 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        if (memread) begin
            fwd_data <= ent_data[hit_idx];
        end
    end

endmodule

`default_nettype wire

// File: logic/data_ram.sv
`default_nettype none

module data_ram
    import lsu_pkg::*;
#(
    parameter int ram_words = 64
) (
    input  logic            clk,
    input  logic            we,
    input  logic [xlen-1:0] waddr,
    input  logic [xlen-1:0] wdata,
    input  logic [3:0]      be,
    input  logic [xlen-1:0] raddr,
    output logic [xlen-1:0] rdata
);

    localparam int aw = (ram_words > 1) ? $clog2(ram_words) : 1;

    logic [xlen-1:0] mem [ram_words];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[waddr[aw-1:0]][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Old contents on a same-cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[raddr[aw-1:0]];
    end

endmodule

`default_nettype wire

// File: logic/load_align.sv
`default_nettype none

module load_align
    import lsu_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  logic             exception,
    input  logic             memread,
    input  logic [2:0]       funct3,
    input  logic [tag_w-1:0] load_phy,
    input  logic [xlen-1:0]  inst_num,
    input  logic [xlen-1:0]  fwd_data,
    input  logic [3:0]       fwd_mask,
    input  logic [xlen-1:0]  ram_rdata,
    output logic             load_done,
    output logic [xlen-1:0]  load_data,
    output logic [1:0]       load_valid,
    output logic [tag_w-1:0] load_phy_out,
    output logic [xlen-1:0]  inst_num_out
);

    logic [2:0]      funct3_q;
    logic [xlen-1:0] word;
    logic [3:0]      need;
    logic [3:0]      got;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_done <= 1'b0;
        end else begin
            load_done <= memread && !exception; // Flush kills the load in flight
        end
    end

    always_ff @(posedge clk) begin
        if (memread) begin
            funct3_q     <= funct3;
            load_phy_out <= load_phy;
            inst_num_out <= inst_num;
        end
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            word[8*b +: 8] = fwd_mask[b] ? fwd_data[8*b +: 8] : ram_rdata[8*b +: 8];
        end

        case (funct3_q)
            f3_b:    load_data = {{24{word[7]}}, word[7:0]};
            f3_bu:   load_data = {24'd0, word[7:0]};
            f3_h:    load_data = {{16{word[15]}}, word[15:0]};
            f3_hu:   load_data = {16'd0, word[15:0]};
            default: load_data = word;
        endcase

        need = load_mask(funct3_q);
        got  = need & fwd_mask;
        if (got == need) begin
            load_valid = cov_full;
        end else if (got != 4'b0000) begin
            load_valid = cov_part;
        end else begin
            load_valid = cov_none;
        end
    end

endmodule

`default_nettype wire

// File: logic/lsu_top.sv
`default_nettype none

module lsu_top
    import lsu_pkg::*;
#(
    parameter int depth     = 8,
    parameter int ram_words = 64
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             exception,
    input  logic             memwrite,
    input  logic             memread,
    input  logic [2:0]       funct3,
    input  logic [xlen-1:0]  mem_addr,
    input  logic [xlen-1:0]  mem_data,
    input  logic [xlen-1:0]  inst_num,
    input  logic [tag_w-1:0] load_phy,
    input  logic             memwrite_rob,
    input  logic [xlen-1:0]  mem_addr_rob,
    input  logic [xlen-1:0]  inst_num_rob,
    output logic             full,
    output logic             load_done,
    output logic [xlen-1:0]  load_data,
    output logic [1:0]       load_valid,
    output logic [tag_w-1:0] load_phy_out,
    output logic [xlen-1:0]  inst_num_out
);

    logic            ram_we;
    logic [xlen-1:0] ram_addr;
    logic [xlen-1:0] ram_wdata;
    logic [3:0]      ram_be;
    logic [xlen-1:0] ram_rdata;
    logic [xlen-1:0] fwd_data;
    logic [3:0]      fwd_mask;

    store_buffer #(
        .depth(depth)
    ) u_sb (
        .clk          (clk),
        .arst_n       (arst_n),
        .exception    (exception),
        .memwrite     (memwrite),
        .memread      (memread),
        .funct3       (funct3),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .inst_num     (inst_num),
        .memwrite_rob (memwrite_rob),
        .mem_addr_rob (mem_addr_rob),
        .inst_num_rob (inst_num_rob),
        .full         (full),
        .fwd_data     (fwd_data),
        .fwd_mask     (fwd_mask),
        .ram_we       (ram_we),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .ram_be       (ram_be)
    );

    data_ram #(
        .ram_words(ram_words)
    ) u_ram (
        .clk   (clk),
        .we    (ram_we),
        .waddr (ram_addr),
        .wdata (ram_wdata),
        .be    (ram_be),
        .raddr (mem_addr), // Read issued with the load
        .rdata (ram_rdata)
    );

    load_align u_align (
        .clk          (clk),
        .arst_n       (arst_n),
        .exception    (exception),
        .memread      (memread),
        .funct3       (funct3),
        .load_phy     (load_phy),
        .inst_num     (inst_num),
        .fwd_data     (fwd_data),
        .fwd_mask     (fwd_mask),
        .ram_rdata    (ram_rdata),
        .load_done    (load_done),
        .load_data    (load_data),
        .load_valid   (load_valid),
        .load_phy_out (load_phy_out),
        .inst_num_out (inst_num_out)
    );

endmodule

`default_nettype wire

// File: tests/lsu_checker.sv
`default_nettype none

module lsu_checker
    import lsu_pkg::*;
(
    input  logic             clk,
    input  logic             load_done,
    input  logic [xlen-1:0]  load_data,
    input  logic [1:0]       load_valid,
    input  logic [tag_w-1:0] load_phy_out,
    input  logic [xlen-1:0]  inst_num_out,
    input  logic             full,
    input  logic             exp_load,
    input  logic             exp_full_chk,
    input  logic [8*16-1:0]  exp_name,
    input  logic [xlen-1:0]  exp_data,
    input  logic [1:0]       exp_cov,
    input  logic [tag_w-1:0] exp_phy,
    input  logic [xlen-1:0]  exp_inum,
    input  logic             exp_full,
    input  logic             report,
    output int               n_pass,
    output int               n_fail
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [8*16-1:0]  q_name [$];
    logic [xlen-1:0]  q_data [$];
    logic [1:0]       q_cov  [$];
    logic [tag_w-1:0] q_phy  [$];
    logic [xlen-1:0]  q_inum [$];

    logic             full_pend = 1'b0;
    logic [8*16-1:0]  full_name;
    logic             full_exp;
    int               passed = 0;
    int               failed = 0;

    assign n_pass = passed;
    assign n_fail = failed;

    // Expectations are taken when the DUT samples the load
    always @(posedge clk) begin
        if (exp_load) begin
            q_name.push_back(exp_name);
            q_data.push_back(exp_data);
            q_cov.push_back(exp_cov);
            q_phy.push_back(exp_phy);
            q_inum.push_back(exp_inum);
        end
        full_pend <= exp_full_chk;
        full_name <= exp_name;
        full_exp  <= exp_full;
    end

    always @(negedge clk) begin : compare
        logic [8*16-1:0]  nm;
        logic [xlen-1:0]  dat;
        logic [1:0]       cv;
        logic [tag_w-1:0] ph;
        logic [xlen-1:0]  inm;
        if (full_pend) begin
            if (full !== full_exp) begin
                $display("FAILED %0s expected full=%b actual full=%b", full_name, full_exp, full);
                failed++;
            end else begin
                $display("PASSED %0s full=%b", full_name, full);
                passed++;
            end
        end
        if (q_data.size() > 0) begin
            nm  = q_name.pop_front();
            dat = q_data.pop_front();
            cv  = q_cov.pop_front();
            ph  = q_phy.pop_front();
            inm = q_inum.pop_front();
            if (load_done !== 1'b1) begin
                $display("%0s: load_done did not rise one cycle after memread", nm); // Timing
                failed++;
            end else if (load_data !== dat || load_valid !== cv
                         || load_phy_out !== ph || inst_num_out !== inm) begin
                $write("FAILED %0s expected data=%h cov=%b phy=%h inum=%h", nm, dat, cv,
                       ph, inm);
                $display(" actual data=%h cov=%b phy=%h inum=%h", load_data, load_valid,
                         load_phy_out, inst_num_out);
                failed++;
            end else begin
                $display("PASSED %0s data=%h cov=%b phy=%h", nm, load_data, load_valid,
                         load_phy_out);
                passed++;
            end
        end else if (load_done === 1'b1) begin
            $display("load_done rose although no load was issued");
            failed++;
        end
    end

    always @(posedge report) begin
        $display("checks run: %0d, passed: %0d, failed: %0d", passed + failed, passed, failed);
    end

endmodule

`default_nettype wire

// File: tests/lsu_tb.sv
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic             clk;
    logic             arst_n;
    logic             exception;
    logic             memwrite;
    logic             memread;
    logic [2:0]       funct3;
    logic [xlen-1:0]  mem_addr;
    logic [xlen-1:0]  mem_data;
    logic [xlen-1:0]  inst_num;
    logic [tag_w-1:0] load_phy;
    logic             memwrite_rob;
    logic [xlen-1:0]  mem_addr_rob;
    logic [xlen-1:0]  inst_num_rob;
    logic             full;
    logic             load_done;
    logic [xlen-1:0]  load_data;
    logic [1:0]       load_valid;
    logic [tag_w-1:0] load_phy_out;
    logic [xlen-1:0]  inst_num_out;

    logic             exp_load;
    logic             exp_full_chk;
    logic [8*16-1:0]  exp_name;
    logic [xlen-1:0]  exp_data;
    logic [1:0]       exp_cov;
    logic [tag_w-1:0] exp_phy;
    logic [xlen-1:0]  exp_inum;
    logic             exp_full;
    logic             report;
    int               n_pass;
    int               n_fail;

    // One entry per pattern line
    logic [7:0]       op_q   [$];
    logic [8*16-1:0]  name_q [$];
    logic [xlen-1:0]  addr_q [$];
    logic [xlen-1:0]  data_q [$];
    logic [2:0]       f3_q   [$];
    logic [xlen-1:0]  inum_q [$];
    logic [tag_w-1:0] phy_q  [$];
    logic [1:0]       cov_q  [$];

    int               n_ops    = 0;
    int               n_checks = 0;
    int               bad_ops  = 0;
    logic             loaded   = 1'b0;

    lsu_top #(
        .depth     (8),
        .ram_words (64)
    ) u_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .exception    (exception),
        .memwrite     (memwrite),
        .memread      (memread),
        .funct3       (funct3),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .inst_num     (inst_num),
        .load_phy     (load_phy),
        .memwrite_rob (memwrite_rob),
        .mem_addr_rob (mem_addr_rob),
        .inst_num_rob (inst_num_rob),
        .full         (full),
        .load_done    (load_done),
        .load_data    (load_data),
        .load_valid   (load_valid),
        .load_phy_out (load_phy_out),
        .inst_num_out (inst_num_out)
    );

    lsu_checker u_chk (
        .clk          (clk),
        .load_done    (load_done),
        .load_data    (load_data),
        .load_valid   (load_valid),
        .load_phy_out (load_phy_out),
        .inst_num_out (inst_num_out),
        .full         (full),
        .exp_load     (exp_load),
        .exp_full_chk (exp_full_chk),
        .exp_name     (exp_name),
        .exp_data     (exp_data),
        .exp_cov      (exp_cov),
        .exp_phy      (exp_phy),
        .exp_inum     (exp_inum),
        .exp_full     (exp_full),
        .report       (report),
        .n_pass       (n_pass),
        .n_fail       (n_fail)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic read_patterns();
        int               fd;
        int               code;
        logic [7:0]       op;
        logic [8*16-1:0]  name;
        logic [8*128-1:0] rest;
        logic [xlen-1:0]  addr;
        logic [xlen-1:0]  data;
        logic [2:0]       f3;
        logic [xlen-1:0]  inum;
        logic [tag_w-1:0] phy;
        logic [1:0]       cov;
        fd = $fopen("tests/lsu_patterns.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", op);
                if (code == 1 && op == "#") begin
                    code = $fgets(rest, fd); // Skip the comment line
                end else if (code == 1) begin
                    code = $fscanf(fd, "%s %h %h %h %h %h %h", name, addr, data, f3, inum,
                                   phy, cov);
                    if (code != 7) begin
                        $display("pattern line after %0d operations is malformed", n_ops);
                        bad_ops++;
                    end else begin
                        op_q.push_back(op);
                        name_q.push_back(name);
                        addr_q.push_back(addr);
                        data_q.push_back(data);
                        f3_q.push_back(f3);
                        inum_q.push_back(inum);
                        phy_q.push_back(phy);
                        cov_q.push_back(cov);
                        if (op == "L" || op == "F") begin
                            n_checks++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
        n_ops = op_q.size();
    endtask

    task automatic clear_strobes();
        exception    = 1'b0;
        memwrite     = 1'b0;
        memread      = 1'b0;
        memwrite_rob = 1'b0;
        exp_load     = 1'b0;
        exp_full_chk = 1'b0;
    endtask

    task automatic drive_line(input int i);
        case (op_q[i])
            "S": begin
                memwrite = 1'b1;
                mem_addr = addr_q[i];
                mem_data = data_q[i];
                funct3   = f3_q[i];
                inst_num = inum_q[i];
            end
            "C": begin
                memwrite_rob = 1'b1;
                mem_addr_rob = addr_q[i];
                inst_num_rob = inum_q[i];
            end
            "L": begin
                memread  = 1'b1;
                mem_addr = addr_q[i];
                funct3   = f3_q[i];
                inst_num = inum_q[i];
                load_phy = phy_q[i];
                exp_load = 1'b1;
                exp_name = name_q[i];
                exp_data = data_q[i];
                exp_cov  = cov_q[i];
                exp_phy  = phy_q[i];
                exp_inum = inum_q[i];
            end
            "X": exception = 1'b1;
            "F": begin
                exp_full_chk = 1'b1;
                exp_name     = name_q[i];
                exp_full     = data_q[i][0];
            end
            "I": ;
            default: begin
                $display("pattern operation %0d has an unknown code", i);
                bad_ops++;
            end
        endcase
    endtask

    initial begin : main
        arst_n       = 1'b0;
        clear_strobes();
        funct3       = f3_w;
        mem_addr     = '0;
        mem_data     = '0;
        inst_num     = '0;
        load_phy     = '0;
        mem_addr_rob = '0;
        inst_num_rob = '0;
        exp_name     = '0;
        exp_data     = '0;
        exp_cov      = cov_none;
        exp_phy      = '0;
        exp_inum     = '0;
        exp_full     = 1'b0;
        report       = 1'b0;
        read_patterns();
        loaded = 1'b1;
        if (n_ops == 0) begin
            $display("no operations could be read from tests/lsu_patterns.txt");
            $display("test failed");
            $finish;
        end else begin
            repeat (4) @(negedge clk);
            arst_n = 1'b1;
            for (int i = 0; i < n_ops; i++) begin
                @(negedge clk);
                clear_strobes();
                drive_line(i);
            end
            @(negedge clk);
            clear_strobes();
            repeat (3) @(negedge clk); // Let the last check land
            report = 1'b1;
            #1;
            if (n_fail == 0 && bad_ops == 0 && n_pass == n_checks) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

    initial begin : watchdog
        wait (loaded);
        #((n_ops + 20) * 20);
        $display("simulation timed out after %0d pattern lines", n_ops);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/lsu_patterns.txt
# op name addr data funct3 inum phy cov, hex fields, funct3 0=b 1=h 2=w 4=bu 5=hu
# data is the store data, the expected load result, or the expected full level on F
S st_w1     00000001 876543a1 2 00000010 00 0
L lw_full   00000001 876543a1 2 00000011 21 3
L lb_full   00000001 ffffffa1 0 00000012 22 3
L lbu_full  00000001 000000a1 4 00000013 23 3
C cm_w1     00000001 00000000 0 00000010 00 0
S st_w2     00000002 11223344 2 00000020 00 0
C cm_w2     00000002 00000000 0 00000020 00 0
S sb_w2     00000002 000000f5 0 00000021 00 0
L lw_part   00000002 112233f5 2 00000022 31 1
L lh_part   00000002 000033f5 1 00000023 32 1
L lb_fwd    00000002 fffffff5 0 00000024 33 3
C cm_sb2    00000002 00000000 0 00000021 00 0
S st_w3     00000003 aabbccdd 2 00000030 00 0
C cm_w3     00000003 00000000 0 00000030 00 0
S sb_w3     00000003 00000011 0 00000031 00 0
S sh_w3     00000003 00008822 1 00000032 00 0
L lw_merge  00000003 aabb8822 2 00000033 41 1
L lh_merge  00000003 ffff8822 1 00000034 42 3
C cm_old3   00000003 00000000 0 00000031 00 0
L lw_defer  00000003 aabb8822 2 00000035 43 1
C cm_new3   00000003 00000000 0 00000032 00 0
L lw_ram3   00000003 aabb8822 2 00000036 44 0
L lhu_ram3  00000003 00008822 5 00000037 45 0
S st_flush  00000001 deadbeef 2 00000040 00 0
L lw_live   00000001 deadbeef 2 00000041 51 3
X flush     00000000 00000000 0 00000000 00 0
L lw_flush  00000001 876543a1 2 00000042 52 0
S st_w16    00000010 0badf00d 2 00000050 00 0
C cm_w16    00000010 00000000 0 00000050 00 0
S fill_0    00000008 a0a0a0a0 2 00000051 00 0
S fill_1    00000009 a1a1a1a1 2 00000052 00 0
S fill_2    0000000a a2a2a2a2 2 00000053 00 0
S fill_3    0000000b a3a3a3a3 2 00000054 00 0
S fill_4    0000000c a4a4a4a4 2 00000055 00 0
S fill_5    0000000d a5a5a5a5 2 00000056 00 0
S fill_6    0000000e a6a6a6a6 2 00000057 00 0
S fill_7    0000000f a7a7a7a7 2 00000058 00 0
F full_on   00000000 00000001 0 00000000 00 0
S st_drop   00000010 12345678 2 00000059 00 0
L lw_drop   00000010 0badf00d 2 0000005a 61 0
C cm_fill0  00000008 00000000 0 00000051 00 0
F full_off  00000000 00000000 0 00000000 00 0
I idle      00000000 00000000 0 00000000 00 0

// File: lsu.f
logic/lsu_pkg.sv
logic/store_buffer.sv
logic/data_ram.sv
logic/load_align.sv
logic/lsu_top.sv
tests/lsu_checker.sv
tests/lsu_tb.sv

// File: run_lsu.sh
#!/bin/sh
# Run from the project root so the pattern file path resolves
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module lsu_tb -f lsu.f -o lsu_sim \
    || exit 1
out=$(./obj_dir/lsu_sim)
echo "$out"
echo "$out" | grep -qx "test passed" && exit 0 || exit 1
